// File: Makefile
SIM      = verilator
FLAGS    = --binary --timing --assert
TOP      = tb_vec_unit
FILELIST = vec_unit.f
OBJDIR   = obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)
	@out="$$(./$(OBJDIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "Verification passed"

clean:
	rm -rf $(OBJDIR)

// File: design/vec_pkg.sv
// Vector unit package.
// Register, lane and vector types, the function codes and the
// instruction word, which decodes in an arithmetic and an immediate view.
`include "vec_params.svh"

package vec_pkg;

    typedef logic [`VEC_REG_AW-1:0]             vreg_t;  // Register number.
    typedef logic [`VEC_LANE_W-1:0]             lane_t;  // One lane word.
    typedef logic [`VEC_LANES*`VEC_LANE_W-1:0]  vec_t;   // Lane 0 in the low word.
    typedef logic [`VEC_LANES-1:0]              mask_t;  // One bit per lane.

    typedef enum logic [3:0] {
        VADD  = 4'h0,  // vd = vs1 + vs2.
        VSUB  = 4'h1,  // vd = vs1 - vs2.
        VAND  = 4'h2,
        VXOR  = 4'h3,
        VSETI = 4'h4,  // Broadcast of the sign-extended immediate.
        VREAD = 4'h5   // Copy one lane of vd to the readout word.
    } vfunct_e;

    typedef struct packed {
        vfunct_e     funct;  // Bits 31..28.
        logic        vm;     // Bit 27, masked by register 0.
        vreg_t       vd;     // Bits 26..24.
        vreg_t       vs1;    // Bits 23..21.
        vreg_t       vs2;    // Bits 20..18.
        logic [17:0] rsvd;
    } vinstr_arith_t;

    typedef struct packed {
        vfunct_e     funct;
        logic        rsvd_hi;   // No masking in this view.
        vreg_t       vd;        // Same place as in the arithmetic view.
        logic [7:0]  rsvd_mid;
        logic [15:0] imm;
    } vinstr_imm_t;

    typedef union packed {
        vinstr_arith_t arith;
        vinstr_imm_t   imm;
    } vinstr_u;

endpackage

// File: design/vec_unit_top.sv
// Vector unit top level.
// Wishbone slave front end, vector register file, lane execute stage
// and writeback, connected as a three-stage pipeline.

module vec_unit_top (
    input  logic           clk_i,
    input  logic           rstn_i,
    input  logic           wb_cyc_i,
    input  logic           wb_stb_i,
    input  logic           wb_we_i,
    input  logic           wb_adr_i,
    input  vec_pkg::lane_t wb_dat_i,
    output vec_pkg::lane_t wb_dat_o,
    output logic           wb_ack_o,
    output logic           busy_o
);
    import vec_pkg::*;

    logic    dec_valid;
    vfunct_e dec_funct;
    logic    dec_vm;
    vreg_t   dec_vd;
    vreg_t   rs1;
    vreg_t   rs2;
    lane_t   dec_imm;
    vec_t    rd_data1;
    vec_t    rd_data2;
    vec_t    rd_old_vd;
    mask_t   rd_mask;
    logic    ex_valid;
    vfunct_e ex_funct;
    vreg_t   ex_vd;
    vec_t    ex_data;
    logic    wr_en;
    vreg_t   wr_addr;
    vec_t    wr_data;
    lane_t   readout;

    assign busy_o = dec_valid | ex_valid;  // Instructions in flight.

    vinstr_decode u_decode (
        .clk_i       (clk_i),
        .rstn_i      (rstn_i),
        .wb_cyc_i    (wb_cyc_i),
        .wb_stb_i    (wb_stb_i),
        .wb_we_i     (wb_we_i),
        .wb_adr_i    (wb_adr_i),
        .wb_dat_i    (wb_dat_i),
        .readout_i   (readout),
        .ex_valid_i  (ex_valid),
        .wb_dat_o    (wb_dat_o),
        .wb_ack_o    (wb_ack_o),
        .dec_valid_o (dec_valid),
        .dec_funct_o (dec_funct),
        .dec_vm_o    (dec_vm),
        .dec_vd_o    (dec_vd),
        .rs1_o       (rs1),
        .rs2_o       (rs2),
        .dec_imm_o   (dec_imm)
    );

    vregfile u_regfile (
        .clk_i              (clk_i),
        .rstn_i             (rstn_i),
        .write_enable_i     (wr_en),
        .write_addr_i       (wr_addr),
        .write_data_i       (wr_data),
        .read_addr1_i       (rs1),
        .read_addr2_i       (rs2),
        .read_addr_old_vd_i (dec_vd),
        .read_addrm_i       (vreg_t'(0)),  // Mask lives in register 0.
        .use_mask_i         (dec_vm),
        .read_data1_o       (rd_data1),
        .read_data2_o       (rd_data2),
        .read_data_old_vd_o (rd_old_vd),
        .read_mask_o        (rd_mask)
    );

    vlane_execute u_execute (
        .clk_i       (clk_i),
        .rstn_i      (rstn_i),
        .dec_valid_i (dec_valid),
        .dec_funct_i (dec_funct),
        .dec_vm_i    (dec_vm),
        .dec_vd_i    (dec_vd),
        .dec_imm_i   (dec_imm),
        .rd_data1_i  (rd_data1),
        .rd_data2_i  (rd_data2),
        .rd_old_vd_i (rd_old_vd),
        .rd_mask_i   (rd_mask),
        .ex_valid_o  (ex_valid),
        .ex_funct_o  (ex_funct),
        .ex_vd_o     (ex_vd),
        .ex_data_o   (ex_data)
    );

    vresult_wb u_result (
        .clk_i      (clk_i),
        .rstn_i     (rstn_i),
        .ex_valid_i (ex_valid),
        .ex_funct_i (ex_funct),
        .ex_vd_i    (ex_vd),
        .ex_data_i  (ex_data),
        .wr_en_o    (wr_en),
        .wr_addr_o  (wr_addr),
        .wr_data_o  (wr_data),
        .readout_o  (readout)
    );

endmodule

// File: design/vinstr_decode.sv
// Instruction decode.
// Wishbone classic slave of the unit. Writes at address 0 carry
// instructions, which are decoded into the first pipeline register.
// Reads return the readout word or the status word and wait for an
// empty pipeline.
`include "vec_params.svh"

module vinstr_decode (
    input  logic             clk_i,
    input  logic             rstn_i,
    input  logic             wb_cyc_i,
    input  logic             wb_stb_i,
    input  logic             wb_we_i,
    input  logic             wb_adr_i,
    input  vec_pkg::lane_t   wb_dat_i,
    input  vec_pkg::lane_t   readout_i,
    input  logic             ex_valid_i,
    output vec_pkg::lane_t   wb_dat_o,
    output logic             wb_ack_o,
    output logic             dec_valid_o,
    output vec_pkg::vfunct_e dec_funct_o,
    output logic             dec_vm_o,
    output vec_pkg::vreg_t   dec_vd_o,
    output vec_pkg::vreg_t   rs1_o,
    output vec_pkg::vreg_t   rs2_o,
    output vec_pkg::lane_t   dec_imm_o
);
    import vec_pkg::*;

    vinstr_u instr;
    logic    funct_ok;
    logic    uses_imm;
    logic    busy;
    logic    wr_req;
    logic    rd_req;
    lane_t   nxt_imm;

    always_comb begin
        instr    = vinstr_u'(wb_dat_i);
        funct_ok = 1'b0;
        uses_imm = 1'b0;
        case (instr.arith.funct)
            VADD, VSUB, VAND, VXOR: funct_ok = 1'b1;
            VSETI, VREAD: begin
                funct_ok = 1'b1;
                uses_imm = 1'b1;
            end
            default: funct_ok = 1'b0;  // Reserved code, dropped.
        endcase
        if (instr.imm.funct == VREAD) begin
            nxt_imm = lane_t'(instr.imm.imm[1:0]);  // Lane number.
        end else begin
            nxt_imm = {{(`VEC_LANE_W-16){instr.imm.imm[15]}}, instr.imm.imm};
        end
    end

    assign busy   = dec_valid_o | ex_valid_i;
    assign wr_req = wb_cyc_i & wb_stb_i & wb_we_i & ~wb_ack_o;
    assign rd_req = wb_cyc_i & wb_stb_i & ~wb_we_i & ~wb_ack_o & ~busy;  // Hold off reads.

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            wb_ack_o    <= 1'b0;
            dec_valid_o <= 1'b0;
            wb_dat_o    <= '0;
        end else begin
            wb_ack_o    <= wr_req | rd_req;  // One pulse per transfer.
            dec_valid_o <= wr_req & funct_ok;
            if (rd_req) begin
                wb_dat_o <= wb_adr_i ? lane_t'(busy) : readout_i;
            end
        end
    end

    // Decode register payload.
    always_ff @(posedge clk_i) begin
        if (wr_req) begin
            dec_funct_o <= instr.arith.funct;
            dec_vm_o    <= instr.arith.vm & ~uses_imm;
            dec_vd_o    <= instr.arith.vd;
            rs1_o       <= instr.arith.vs1;
            rs2_o       <= instr.arith.vs2;
            dec_imm_o   <= nxt_imm;
        end
    end

    // The ack drops for a cycle before the master's next transfer.
    a_ack_single: assert property (@(posedge clk_i) disable iff (!rstn_i)
        (wb_ack_o && wb_stb_i) |=> !(wb_ack_o && wb_stb_i));

endmodule

// File: design/vlane_execute.sv
// Lane execute stage.
// Computes the lane-wise result of the decoded instruction, merges
// masked-off lanes from the old destination and registers the result.
// VREAD moves the addressed lane of vd into lane 0.
`include "vec_params.svh"

module vlane_execute (
    input  logic             clk_i,
    input  logic             rstn_i,
    input  logic             dec_valid_i,
    input  vec_pkg::vfunct_e dec_funct_i,
    input  logic             dec_vm_i,
    input  vec_pkg::vreg_t   dec_vd_i,
    input  vec_pkg::lane_t   dec_imm_i,
    input  vec_pkg::vec_t    rd_data1_i,
    input  vec_pkg::vec_t    rd_data2_i,
    input  vec_pkg::vec_t    rd_old_vd_i,
    input  vec_pkg::mask_t   rd_mask_i,
    output logic             ex_valid_o,
    output vec_pkg::vfunct_e ex_funct_o,
    output vec_pkg::vreg_t   ex_vd_o,
    output vec_pkg::vec_t    ex_data_o
);
    import vec_pkg::*;

    localparam int LANE_SW = $clog2(`VEC_LANES);

    lane_t a;
    lane_t b;
    lane_t old;
    lane_t op;
    vec_t  result;

    always_comb begin
        result = '0;
        for (int l = 0; l < `VEC_LANES; l++) begin
            a   = rd_data1_i[l*`VEC_LANE_W +: `VEC_LANE_W];
            b   = rd_data2_i[l*`VEC_LANE_W +: `VEC_LANE_W];
            old = rd_old_vd_i[l*`VEC_LANE_W +: `VEC_LANE_W];
            case (dec_funct_i)
                VADD:    op = a + b;  // Wraps at lane width.
                VSUB:    op = a - b;
                VAND:    op = a & b;
                VXOR:    op = a ^ b;
                VSETI:   op = dec_imm_i;
                default: op = '0;
            endcase
            if (!dec_vm_i || rd_mask_i[l]) begin
                result[l*`VEC_LANE_W +: `VEC_LANE_W] = op;
            end else begin
                result[l*`VEC_LANE_W +: `VEC_LANE_W] = old;  // Lane masked off.
            end
        end
        if (dec_funct_i == VREAD) begin
            result = vec_t'(rd_old_vd_i[dec_imm_i[LANE_SW-1:0]*`VEC_LANE_W +: `VEC_LANE_W]);
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            ex_valid_o <= 1'b0;
        end else begin
            ex_valid_o <= dec_valid_i;
        end
    end

    always_ff @(posedge clk_i) begin
        ex_funct_o <= dec_funct_i;
        ex_vd_o    <= dec_vd_i;
        ex_data_o  <= result;
    end

    // Decode clears vm for immediate-form instructions.
    a_vread_unmasked: assert property (@(posedge clk_i) disable iff (!rstn_i)
        (dec_valid_i && dec_funct_i == VREAD) |-> !dec_vm_i);

endmodule

// File: design/vregfile.sv
// Vector register file.
// Physical vector registers with three data read ports, a mask read
// port and one write port. A write in progress is forwarded to any read
// port addressing the same register.
`include "vec_params.svh"

module vregfile (
    input  logic           clk_i,
    input  logic           rstn_i,
    input  logic           write_enable_i,
    input  vec_pkg::vreg_t write_addr_i,
    input  vec_pkg::vec_t  write_data_i,
    input  vec_pkg::vreg_t read_addr1_i,
    input  vec_pkg::vreg_t read_addr2_i,
    input  vec_pkg::vreg_t read_addr_old_vd_i,
    input  vec_pkg::vreg_t read_addrm_i,
    input  logic           use_mask_i,
    output vec_pkg::vec_t  read_data1_o,
    output vec_pkg::vec_t  read_data2_o,
    output vec_pkg::vec_t  read_data_old_vd_o,
    output vec_pkg::mask_t read_mask_o
);
    import vec_pkg::*;

    vec_t registers [`VEC_NUM_REGS];
    logic bypass1;
    logic bypass2;
    logic bypass_old_vd;
    logic bypassm;
    vec_t mask_src;

    always_comb begin
        bypass1       = write_enable_i && (write_addr_i == read_addr1_i);
        bypass2       = write_enable_i && (write_addr_i == read_addr2_i);
        bypass_old_vd = write_enable_i && (write_addr_i == read_addr_old_vd_i);
        bypassm       = write_enable_i && (write_addr_i == read_addrm_i);

        if (bypass1) begin
            read_data1_o = write_data_i;
        end else begin
            read_data1_o = registers[read_addr1_i];
        end

        if (bypass2) begin
            read_data2_o = write_data_i;
        end else begin
            read_data2_o = registers[read_addr2_i];
        end

        if (bypass_old_vd) begin
            read_data_old_vd_o = write_data_i;
        end else begin
            read_data_old_vd_o = registers[read_addr_old_vd_i];
        end

        mask_src = bypassm ? write_data_i : registers[read_addrm_i];
        if (use_mask_i) begin
            read_mask_o = mask_src[`VEC_LANES-1:0];  // Low bits of the mask register.
        end else begin
            read_mask_o = '1;  // Unmasked, every lane enabled.
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            for (int i = 0; i < `VEC_NUM_REGS; i++) begin
                registers[i] <= '0;
            end
        end else if (write_enable_i) begin
            registers[write_addr_i] <= write_data_i;
        end
    end

    a_we_known: assert property (@(posedge clk_i) disable iff (!rstn_i)
        !$isunknown(write_enable_i));

endmodule

// File: design/vresult_wb.sv
// Writeback stage.
// Registers the execute result and drives the register file write port.
// VREAD results go to the readout word instead.
`include "vec_params.svh"

module vresult_wb (
    input  logic             clk_i,
    input  logic             rstn_i,
    input  logic             ex_valid_i,
    input  vec_pkg::vfunct_e ex_funct_i,
    input  vec_pkg::vreg_t   ex_vd_i,
    input  vec_pkg::vec_t    ex_data_i,
    output logic             wr_en_o,
    output vec_pkg::vreg_t   wr_addr_o,
    output vec_pkg::vec_t    wr_data_o,
    output vec_pkg::lane_t   readout_o
);
    import vec_pkg::*;

    logic is_read;

    assign is_read = (ex_funct_i == VREAD);

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            wr_en_o   <= 1'b0;
            readout_o <= '0;
        end else begin
            wr_en_o <= ex_valid_i & ~is_read;
            if (ex_valid_i && is_read) begin
                readout_o <= ex_data_i[`VEC_LANE_W-1:0];  // Lane 0 holds the selected word.
            end
        end
    end

    always_ff @(posedge clk_i) begin
        wr_addr_o <= ex_vd_i;
        wr_data_o <= ex_data_i;
    end

endmodule

// File: include/vec_params.svh
// Vector unit parameters.
// Lane count, lane width and the size of the vector register file.
`ifndef VEC_PARAMS_SVH
`define VEC_PARAMS_SVH

// Lanes per vector.
`define VEC_LANES 4

// Bits per lane.
`define VEC_LANE_W 32

// Physical vector registers and their address width.
`define VEC_NUM_REGS 8
`define VEC_REG_AW 3

`endif

// File: tb/tb_vec_unit.sv
// Vector unit testbench.
// Replays Wishbone instruction writes and readout or status reads from
// tb/vec_input.txt and checks each returned word and every ack pulse.

module tb_vec_unit;
    timeunit 1ns;
    timeprecision 100ps;

    import vec_pkg::*;

    logic  clk_i;
    logic  rstn_i;
    logic  wb_cyc_i;
    logic  wb_stb_i;
    logic  wb_we_i;
    logic  wb_adr_i;
    lane_t wb_dat_i;
    lane_t wb_dat_o;
    logic  wb_ack_o;
    logic  busy_o;

    byte         op_q[$];         // Line type per entry.
    lane_t       val_q[$];        // Instruction or expected word.
    int          n_lines = 0;
    int          cycle_limit = 0;
    int          cycles = 0;
    int          errors = 0;
    int          tests = 0;
    int          failed_tests = 0;
    logic [15:0] lfsr;

    vec_unit_top dut0 (
        .clk_i    (clk_i),
        .rstn_i   (rstn_i),
        .wb_cyc_i (wb_cyc_i),
        .wb_stb_i (wb_stb_i),
        .wb_we_i  (wb_we_i),
        .wb_adr_i (wb_adr_i),
        .wb_dat_i (wb_dat_i),
        .wb_dat_o (wb_dat_o),
        .wb_ack_o (wb_ack_o),
        .busy_o   (busy_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #4 clk_i = ~clk_i;  // 8 ns period.
    end

    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 16'hB400;  // Taps 16, 14, 13, 11.
        end
        return s >> 1;
    endfunction

    // Idle cycles before a transfer, 0 to 3.
    function automatic int next_gap();
        int g;
        g = 0;
        for (int i = 0; i < 2; i++) begin
            g = (g << 1) | int'(lfsr[0]);
            lfsr = lfsr_step(lfsr);
        end
        return g;
    endfunction

    task automatic check_lane(input string name, input lane_t got, input lane_t exp,
                              output bit ok);
        ok = (got === exp);
        if (!ok) begin
            errors++;
            $display("** Error at %0t: %s = %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_ack(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            errors++;
            $display("** Error at %0t: %s = %b, expected %b", $time, name, got, exp);
        end
    endtask

    task automatic load_file();
        int    fd;
        int    n;
        byte   c;
        lane_t v;
        string line;
        fd = $fopen("tb/vec_input.txt", "r");
        if (fd == 0) begin
            errors++;
            $display("Could not open tb/vec_input.txt, no stimulus was run.");
            return;
        end
        while (!$feof(fd)) begin
            n = $fscanf(fd, " %c", c);
            if (n != 1) begin
                break;
            end
            n_lines++;
            if (c == "#") begin
                n = $fgets(line, fd);  // Rest of a comment line.
            end else begin
                n = $fscanf(fd, " %h", v);
                op_q.push_back(c);
                val_q.push_back(v);
            end
        end
        $fclose(fd);
    endtask

    task automatic idle_cycles(input int n);
        for (int i = 0; i < n; i++) begin
            @(posedge clk_i);
            wb_cyc_i <= 1'b0;
            wb_stb_i <= 1'b0;
            wb_we_i  <= 1'b0;
            @(negedge clk_i);
            check_ack("wb_ack_o", wb_ack_o, 1'b0);  // No ack without a request.
        end
    endtask

    task automatic bus_transfer(input logic we, input logic adr, input lane_t data,
                                output lane_t rdata);
        @(posedge clk_i);
        wb_cyc_i <= 1'b1;
        wb_stb_i <= 1'b1;
        wb_we_i  <= we;
        wb_adr_i <= adr;
        wb_dat_i <= data;
        @(negedge clk_i);
        check_ack("wb_ack_o", wb_ack_o, 1'b0);  // Previous pulse has ended.
        while (!wb_ack_o) begin
            @(negedge clk_i);
        end
        rdata = wb_dat_o;
        if (we) begin
            check_ack("busy_o", busy_o, data[31:28] <= 4'h5);  // A defined code fills decode.
        end else begin
            check_ack("busy_o", busy_o, 1'b0);  // Reads end on an empty pipeline.
        end
    endtask

    initial begin : watchdog
        wait (cycle_limit > 0);
        while (cycles < cycle_limit) begin
            @(posedge clk_i);
            cycles++;
        end
        $display("Timeout after %0d cycles, a transfer was never acknowledged.", cycles);
        $display("Verification failed");
        $finish;
    end

    initial begin
        string kind;
        bit    ok;
        lane_t rdata;
        int    gap;
        rstn_i   = 1'b0;
        wb_cyc_i = 1'b0;
        wb_stb_i = 1'b0;
        wb_we_i  = 1'b0;
        wb_adr_i = 1'b0;
        wb_dat_i = '0;
        lfsr     = 16'd86;
        load_file();
        cycle_limit = 12 * n_lines + 50;
        repeat (5) @(posedge clk_i);
        rstn_i <= 1'b1;
        for (int i = 0; i < op_q.size(); i++) begin
            gap = (op_q[i] == "B") ? 0 : next_gap();  // B lines issue back to back.
            idle_cycles(gap);
            case (op_q[i])
                "W", "B": bus_transfer(1'b1, 1'b0, val_q[i], rdata);
                "R", "S": begin
                    bus_transfer(1'b0, op_q[i] == "S", '0, rdata);
                    kind = (op_q[i] == "S") ? "status" : "readout";
                    check_lane("wb_dat_o", rdata, val_q[i], ok);
                    tests++;
                    if (!ok) begin
                        failed_tests++;
                    end
                    $display("Test %0d %s read: got %h, expected %h, %s", tests, kind,
                             rdata, val_q[i], ok ? "ok" : "FAILED");
                end
                default: begin
                    errors++;
                    $display("Data file entry %0d has an unknown line type.", i);
                end
            endcase
        end
        idle_cycles(1);
        $display("Tests: %0d run, %0d failed, %0d check errors", tests, failed_tests, errors);
        if (errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

// File: tb/vec_input.txt
# Column 1: W write instruction after an idle gap, B write with no gap,
# R read readout word, S read status. Column 2: instruction or expected word in hex.
# Reset state.
S 00000000
W 53000002
R 00000000
# VSETI of a negative immediate, every lane.
W 41008001
W 51000000
R FFFF8001
W 51000001
R FFFF8001
W 51000002
R FFFF8001
W 51000003
R FFFF8001
# Arithmetic functions.
W 42008123
W 03280000
W 14280000
W 25680000
W 36640000
W 53000000
R FFFF0124
W 54000002
R FFFFFEDE
W 55000001
R FFFF0120
W 56000003
R 00008125
# Masked VADD with mask 0101 in v0.
W 40000005
W 47000777
W 0F280000
W 57000000
R FFFF0124
W 57000001
R 00000777
W 57000002
R FFFF0124
W 57000003
R 00000777
# Dependent chain issued back to back.
W 05280000
B 04B40000
B 33840000
B 53000002
R 00018249
W 54000000
R FFFE0248
# Reserved function code is dropped.
W F0000000
S 00000000

// File: vec_unit.f
+incdir+include
design/vec_pkg.sv
design/vinstr_decode.sv
design/vregfile.sv
design/vlane_execute.sv
design/vresult_wb.sv
design/vec_unit_top.sv
tb/tb_vec_unit.sv
